/* src/accelCfgPkg.sv */
`default_nettype none

package accelCfgPkg;

    // Lanes and memory geometry
    localparam int LANES     = 4;
    localparam int LANE_BITS = $clog2(LANES);
    localparam int MAX_ELEMS = 256;
    localparam int ELEM_BITS = $clog2(MAX_ELEMS);
    localparam int ROW_BITS  = ELEM_BITS - LANE_BITS;

    // Arithmetic widths
    localparam int SAMPLE_W = 16;
    localparam int ACC_W    = 40;
    localparam int LEN_W    = ELEM_BITS + 1;

    // Output FIFO and pipeline depths
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int PIPE_SKID  = 8;
    localparam int MEM_LAT    = 3;

    // Generator FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_INIT = 2'd1;
    localparam logic [1:0] ST_CALC = 2'd2;

endpackage

`default_nettype wire

/* src/accelAddrPkg.sv */
`default_nettype none

package accelAddrPkg;

    // One element address, seen flat by the generator
    // and as bank row plus lane by the memory
    typedef union packed {
        logic [accelCfgPkg::ELEM_BITS-1:0] flat;
        struct packed {
            logic [accelCfgPkg::ROW_BITS-1:0]  bankRow;
            logic [accelCfgPkg::LANE_BITS-1:0] lane;
        } idx;
    } elemAddrT;

    // Host bus map
    localparam int BUS_ADDR_W = accelCfgPkg::ELEM_BITS + 1;

    // Set for filter memory, clear for data memory
    localparam int SEL_FILT_BIT = accelCfgPkg::ELEM_BITS;

endpackage

`default_nettype wire

/* src/convAddrGen.sv */
`default_nettype none

module convAddrGen (
    input  logic                              clkIn,
    input  logic                              rstIn,
    input  logic                              startIn,
    input  logic [accelCfgPkg::LEN_W-1:0]     dataLenIn,
    input  logic [accelCfgPkg::LEN_W-1:0]     filtLenIn,
    input  logic                              fifoSpace,
    output logic                              rdValid,
    output accelAddrPkg::elemAddrT            dataAddr,
    output accelAddrPkg::elemAddrT            filtAddr,
    output logic [accelCfgPkg::LANES-1:0]     laneMask,
    output logic                              beatLast
);
    import accelCfgPkg::*;

    logic [1:0]           stateR;
    logic [LEN_W-1:0]     dataLenR;
    logic [LEN_W-1:0]     filtLenR;
    logic [ELEM_BITS-1:0] maxBaseR;
    logic [ELEM_BITS-1:0] lastChunkR;
    logic [ELEM_BITS-1:0] baseCntR;
    logic [ELEM_BITS-1:0] chunkCntR;
    logic                 fire;
    logic                 chunkDone;
    logic [LANES-1:0]     chunkMask;

    // One beat per cycle, only while the FIFO can absorb the skid
    assign fire      = (stateR == ST_CALC) && fifoSpace;
    assign chunkDone = (chunkCntR == lastChunkR);

    // Lanes past the filter end are off
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            chunkMask[k] = (LEN_W'(chunkCntR) + LEN_W'(k)) < filtLenR;
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            stateR  <= ST_IDLE;
            rdValid <= 1'b0;
        end else begin
            rdValid <= fire;
            case (stateR)
                ST_IDLE: begin
                    if (startIn) begin
                        stateR <= ST_INIT;
                    end
                end
                ST_INIT: begin
                    stateR <= ST_CALC;
                end
                ST_CALC: begin
                    if (fire && chunkDone && (baseCntR == maxBaseR)) begin
                        stateR <= ST_IDLE;
                    end
                end
                default: begin
                    stateR <= ST_IDLE;
                end
            endcase
        end
    end

    // Window base and chunk counters
    always_ff @(posedge clkIn) begin
        if (stateR == ST_IDLE) begin
            dataLenR <= dataLenIn;
            filtLenR <= filtLenIn;
        end
        if (stateR == ST_INIT) begin
            maxBaseR   <= ELEM_BITS'(dataLenR - filtLenR);
            // Offset of the final chunk, lane aligned
            lastChunkR <= ELEM_BITS'(filtLenR - 1) & ~ELEM_BITS'(LANES - 1);
            baseCntR   <= '0;
            chunkCntR  <= '0;
        end else if (fire) begin
            if (chunkDone) begin
                chunkCntR <= '0;
                baseCntR  <= baseCntR + 1'b1;
            end else begin
                chunkCntR <= chunkCntR + ELEM_BITS'(LANES);
            end
        end
    end

    // Beat payload
    always_ff @(posedge clkIn) begin
        dataAddr.flat <= baseCntR + chunkCntR;
        filtAddr.flat <= chunkCntR;
        laneMask      <= chunkMask;
        beatLast      <= chunkDone;
    end

endmodule

`default_nettype wire

/* src/convBankedMem.sv */
`default_nettype none

module convBankedMem (
    input  logic                                                       clkIn,
    input  logic                                                       rstIn,
    input  logic [accelAddrPkg::BUS_ADDR_W-1:0]                        addrIn,
    input  logic                                                       wrEnIn,
    input  logic [accelCfgPkg::SAMPLE_W-1:0]                           wrDataIn,
    input  logic                                                       rdValid,
    input  accelAddrPkg::elemAddrT                                     dataAddr,
    input  accelAddrPkg::elemAddrT                                     filtAddr,
    input  logic [accelCfgPkg::LANES-1:0]                              laneMask,
    input  logic                                                       beatLast,
    output logic                                                       vecValid,
    output logic                                                       vecLast,
    output logic [accelCfgPkg::LANES-1:0][accelCfgPkg::SAMPLE_W-1:0]   dataVec,
    output logic [accelCfgPkg::LANES-1:0][accelCfgPkg::SAMPLE_W-1:0]   filtVec,
    output logic [accelCfgPkg::LANES-1:0]                              vecMask
);
    import accelCfgPkg::*;
    import accelAddrPkg::*;

    elemAddrT             wrAddr;
    logic                 wrFilt;
    logic [ROW_BITS-1:0]  dataRowR [LANES];
    logic [ROW_BITS-1:0]  filtRowR;
    logic [LANES-1:0]     dataEnR;
    logic [LANES-1:0]     filtEnR;
    logic [SAMPLE_W-1:0]  dataRdR [LANES];
    logic [SAMPLE_W-1:0]  filtRdR [LANES];
    logic [MEM_LAT-1:0]   validD;
    logic [MEM_LAT-1:0]   lastD;
    logic [LANES-1:0]     maskD [MEM_LAT];
    logic [LANE_BITS-1:0] laneD [MEM_LAT-1];

    assign wrAddr.flat = addrIn[ELEM_BITS-1:0];
    assign wrFilt      = addrIn[SEL_FILT_BIT];

    // Stage 1, enables rotated into bank order
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            dataEnR <= '0;
            filtEnR <= '0;
        end else begin
            for (int b = 0; b < LANES; b++) begin
                dataEnR[b] <= rdValid && laneMask[LANE_BITS'(b) - dataAddr.idx.lane];
            end
            filtEnR <= rdValid ? laneMask : '0;
        end
    end

    // Banks below the start lane hold the next row of the window
    always_ff @(posedge clkIn) begin
        for (int b = 0; b < LANES; b++) begin
            dataRowR[b] <= dataAddr.idx.bankRow
                         + ROW_BITS'(LANE_BITS'(b) < dataAddr.idx.lane);
        end
        filtRowR <= filtAddr.idx.bankRow;
    end

    // Stage 2, one RAM pair per bank
    for (genvar b = 0; b < LANES; b++) begin : gBank
        logic [SAMPLE_W-1:0] ram [2][MAX_ELEMS/LANES];

        always_ff @(posedge clkIn) begin
            if (wrEnIn && (wrAddr.idx.lane == LANE_BITS'(b))) begin
                ram[wrFilt][wrAddr.idx.bankRow] <= wrDataIn;
            end
            if (dataEnR[b]) begin
                dataRdR[b] <= ram[0][dataRowR[b]];
            end
            if (filtEnR[b]) begin
                filtRdR[b] <= ram[1][filtRowR];
            end
        end
    end

    // Beat side info delayed alongside the read
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            validD <= '0;
        end else begin
            validD <= {validD[MEM_LAT-2:0], rdValid};
        end
    end

    always_ff @(posedge clkIn) begin
        lastD    <= {lastD[MEM_LAT-2:0], beatLast};
        maskD[0] <= laneMask;
        laneD[0] <= dataAddr.idx.lane;
        for (int s = 1; s < MEM_LAT; s++) begin
            maskD[s] <= maskD[s-1];
        end
        for (int s = 1; s < MEM_LAT - 1; s++) begin
            laneD[s] <= laneD[s-1];
        end
    end

    // Stage 3, rotate data back to vector lane order
    always_ff @(posedge clkIn) begin
        for (int k = 0; k < LANES; k++) begin
            dataVec[k] <= dataRdR[LANE_BITS'(k) + laneD[MEM_LAT-2]];
            filtVec[k] <= filtRdR[k];
        end
    end

    assign vecValid = validD[MEM_LAT-1];
    assign vecLast  = lastD[MEM_LAT-1];
    assign vecMask  = maskD[MEM_LAT-1];

endmodule

`default_nettype wire

/* src/convMac.sv */
`default_nettype none

module convMac (
    input  logic                                                      clkIn,
    input  logic                                                      rstIn,
    input  logic                                                      vecValid,
    input  logic                                                      vecLast,
    input  logic [accelCfgPkg::LANES-1:0][accelCfgPkg::SAMPLE_W-1:0]  dataVec,
    input  logic [accelCfgPkg::LANES-1:0][accelCfgPkg::SAMPLE_W-1:0]  filtVec,
    input  logic [accelCfgPkg::LANES-1:0]                             vecMask,
    output logic                                                      resValid,
    output logic [accelCfgPkg::ACC_W-1:0]                             resData
);
    import accelCfgPkg::*;

    logic signed [2*SAMPLE_W-1:0] prodR [LANES];
    logic signed [ACC_W-1:0]      laneSum;
    logic signed [ACC_W-1:0]      sumR;
    logic signed [ACC_W-1:0]      accR;
    logic                         validA;
    logic                         lastA;
    logic                         validB;
    logic                         lastB;

    // Masked lane products
    always_ff @(posedge clkIn) begin
        for (int k = 0; k < LANES; k++) begin
            if (vecMask[k]) begin
                prodR[k] <= $signed(dataVec[k]) * $signed(filtVec[k]);
            end else begin
                prodR[k] <= '0;
            end
        end
        lastA <= vecLast;
        sumR  <= laneSum;
        lastB <= lastA;
        resData <= accR + sumR;
    end

    // Sign-extended lane reduction
    always_comb begin
        laneSum = '0;
        for (int k = 0; k < LANES; k++) begin
            laneSum = laneSum + ACC_W'(prodR[k]);
        end
    end

    // Accumulator restarts once a window closes
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            validA   <= 1'b0;
            validB   <= 1'b0;
            resValid <= 1'b0;
            accR     <= '0;
        end else begin
            validA   <= vecValid;
            validB   <= validA;
            resValid <= validB && lastB;
            if (validB) begin
                accR <= lastB ? '0 : accR + sumR;
            end
        end
    end

endmodule

`default_nettype wire

/* src/convOutFifo.sv */
`default_nettype none

module convOutFifo (
    input  logic                            clkIn,
    input  logic                            rstIn,
    input  logic                            resValid,
    input  logic [accelCfgPkg::ACC_W-1:0]   resData,
    input  logic                            readyIn,
    output logic                            validOut,
    output logic [accelCfgPkg::ACC_W-1:0]   dataOut,
    output logic                            fifoSpace
);
    import accelCfgPkg::*;

    logic [ACC_W-1:0]      fifoMem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wrPtrR;
    logic [FIFO_PTR_W-1:0] rdPtrR;
    logic [FIFO_CNT_W-1:0] countR;
    logic                  pop;

    assign validOut = (countR != '0);
    assign dataOut  = fifoMem[rdPtrR];
    assign pop      = validOut && readyIn;

    // Room left for every beat the generator may still have in flight
    assign fifoSpace = (countR <= FIFO_CNT_W'(FIFO_DEPTH - PIPE_SKID));

    always_ff @(posedge clkIn) begin
        if (resValid) begin
            fifoMem[wrPtrR] <= resData;
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtrR <= '0;
            rdPtrR <= '0;
            countR <= '0;
        end else begin
            if (resValid) begin
                wrPtrR <= wrPtrR + 1'b1;
            end
            if (pop) begin
                rdPtrR <= rdPtrR + 1'b1;
            end
            case ({resValid, pop})
                2'b10:   countR <= countR + 1'b1;
                2'b01:   countR <= countR - 1'b1;
                default: countR <= countR;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/convAccelTop.sv */
`default_nettype none

module convAccelTop (
    input  logic                                clkIn,
    input  logic                                rstIn,
    input  logic                                startIn,
    input  logic [accelCfgPkg::LEN_W-1:0]       dataLenIn,
    input  logic [accelCfgPkg::LEN_W-1:0]       filtLenIn,
    input  logic [accelAddrPkg::BUS_ADDR_W-1:0] addrIn,
    input  logic                                wrEnIn,
    input  logic [accelCfgPkg::SAMPLE_W-1:0]    wrDataIn,
    input  logic                                readyIn,
    output logic                                validOut,
    output logic [accelCfgPkg::ACC_W-1:0]       dataOut
);
    import accelCfgPkg::*;
    import accelAddrPkg::*;

    // Generator to memory
    logic                 rdValid;
    elemAddrT             dataAddr;
    elemAddrT             filtAddr;
    logic [LANES-1:0]     laneMask;
    logic                 beatLast;

    // Memory to MAC
    logic                               vecValid;
    logic                               vecLast;
    logic [LANES-1:0][SAMPLE_W-1:0]     dataVec;
    logic [LANES-1:0][SAMPLE_W-1:0]     filtVec;
    logic [LANES-1:0]                   vecMask;

    // MAC to FIFO, and FIFO back to the generator
    logic                 resValid;
    logic [ACC_W-1:0]     resData;
    logic                 fifoSpace;

    convAddrGen i_convAddrGen (
        .clkIn     (clkIn),
        .rstIn     (rstIn),
        .startIn   (startIn),
        .dataLenIn (dataLenIn),
        .filtLenIn (filtLenIn),
        .fifoSpace (fifoSpace),
        .rdValid   (rdValid),
        .dataAddr  (dataAddr),
        .filtAddr  (filtAddr),
        .laneMask  (laneMask),
        .beatLast  (beatLast)
    );

    convBankedMem i_convBankedMem (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .addrIn   (addrIn),
        .wrEnIn   (wrEnIn),
        .wrDataIn (wrDataIn),
        .rdValid  (rdValid),
        .dataAddr (dataAddr),
        .filtAddr (filtAddr),
        .laneMask (laneMask),
        .beatLast (beatLast),
        .vecValid (vecValid),
        .vecLast  (vecLast),
        .dataVec  (dataVec),
        .filtVec  (filtVec),
        .vecMask  (vecMask)
    );

    convMac i_convMac (
        .clkIn    (clkIn),
        .rstIn    (rstIn),
        .vecValid (vecValid),
        .vecLast  (vecLast),
        .dataVec  (dataVec),
        .filtVec  (filtVec),
        .vecMask  (vecMask),
        .resValid (resValid),
        .resData  (resData)
    );

    convOutFifo i_convOutFifo (
        .clkIn     (clkIn),
        .rstIn     (rstIn),
        .resValid  (resValid),
        .resData   (resData),
        .readyIn   (readyIn),
        .validOut  (validOut),
        .dataOut   (dataOut),
        .fifoSpace (fifoSpace)
    );

endmodule

`default_nettype wire

/* tests/convAccel_checker.sv */
`default_nettype none

module convAccelChecker (
    input logic                          clkIn,
    input logic                          rstIn,
    input logic                          readyIn,
    input logic                          validOut,
    input logic [accelCfgPkg::ACC_W-1:0] dataOut
);

    // FIFO comes out of reset empty
    resetClearsValid: assert property (
        @(posedge clkIn) rstIn |=> !validOut
    ) else $error("validOut high in the cycle after reset");

    // Stalled output word must not move
    holdWhileStalled: assert property (
        @(posedge clkIn) disable iff (rstIn)
        (validOut && !readyIn) |=> (validOut && $stable(dataOut))
    ) else $error("dataOut or validOut changed while stalled by readyIn");

    validKnown: assert property (
        @(posedge clkIn) disable iff (rstIn)
        !$isunknown(validOut)
    ) else $error("validOut is unknown outside reset");

endmodule

bind convAccelTop convAccelChecker i_convAccelChecker (
    .clkIn    (clkIn),
    .rstIn    (rstIn),
    .readyIn  (readyIn),
    .validOut (validOut),
    .dataOut  (dataOut)
);

`default_nettype wire

/* tests/convAccelTb.sv */
`default_nettype none

module convAccelTb;
    import accelCfgPkg::*;
    import accelAddrPkg::*;

    // Results over all runs: 25 + 26 + 32 + 52 + 36
    localparam int TOTAL_RESULTS = 171;

    logic                  clkIn;
    logic                  rstIn;
    logic                  startIn;
    logic [LEN_W-1:0]      dataLenIn;
    logic [LEN_W-1:0]      filtLenIn;
    logic [BUS_ADDR_W-1:0] addrIn;
    logic                  wrEnIn;
    logic [SAMPLE_W-1:0]   wrDataIn;
    logic                  readyIn;
    logic                  validOut;
    logic [ACC_W-1:0]      dataOut;

    integer                      seed;
    int                          receivedCount;
    logic signed [SAMPLE_W-1:0]  dataModel [MAX_ELEMS];
    logic signed [SAMPLE_W-1:0]  filtModel [MAX_ELEMS];
    logic [ACC_W-1:0]            expQ [$];

    convAccelTop i_convAccelTop (
        .clkIn     (clkIn),
        .rstIn     (rstIn),
        .startIn   (startIn),
        .dataLenIn (dataLenIn),
        .filtLenIn (filtLenIn),
        .addrIn    (addrIn),
        .wrEnIn    (wrEnIn),
        .wrDataIn  (wrDataIn),
        .readyIn   (readyIn),
        .validOut  (validOut),
        .dataOut   (dataOut)
    );

    initial begin
        clkIn = 1'b0;
        forever #20 clkIn = ~clkIn;
    end

    task automatic stopOnError();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // One host write, mirrored into the model memories
    task automatic writeElem(input bit toFilt, input int idx, input logic [SAMPLE_W-1:0] value);
        logic [BUS_ADDR_W-1:0] addr;
        addr = '0;
        addr[SEL_FILT_BIT] = toFilt;
        addr[ELEM_BITS-1:0] = ELEM_BITS'(idx);
        @(negedge clkIn);
        addrIn   = addr;
        wrEnIn   = 1'b1;
        wrDataIn = value;
        if (toFilt) begin
            filtModel[ELEM_BITS'(idx)] = value;
        end else begin
            dataModel[ELEM_BITS'(idx)] = value;
        end
    endtask

    task automatic fillRandom(input bit toFilt, input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $random(seed);
            writeElem(toFilt, i, rnd[SAMPLE_W-1:0]);
        end
        @(negedge clkIn);
        wrEnIn = 1'b0;
    endtask

    // Sum over j of data[b+j] * filt[j] for every window base
    task automatic queueExpected(input int dataLen, input int filtLen);
        longint acc;
        for (int b = 0; b <= dataLen - filtLen; b++) begin
            acc = 0;
            for (int j = 0; j < filtLen; j++) begin
                acc += longint'(dataModel[ELEM_BITS'(b + j)]) * longint'(filtModel[ELEM_BITS'(j)]);
            end
            expQ.push_back(ACC_W'(acc));
        end
    endtask

    // Throttled mode keeps readyIn mostly low so the FIFO fills up
    task automatic drainResults(input bit throttle);
        logic [31:0] rnd;
        while (expQ.size() != 0) begin
            @(negedge clkIn);
            if (throttle) begin
                rnd = $random(seed);
                readyIn = (rnd[2:0] == 3'd0);
            end else begin
                readyIn = 1'b1;
            end
        end
        @(negedge clkIn);
        readyIn = 1'b1;
    endtask

    task automatic runWindows(input int dataLen, input int filtLen, input bit throttle);
        queueExpected(dataLen, filtLen);
        @(negedge clkIn);
        dataLenIn = LEN_W'(dataLen);
        filtLenIn = LEN_W'(filtLen);
        startIn   = 1'b1;
        @(negedge clkIn);
        startIn = 1'b0;
        drainResults(throttle);
    endtask

    task automatic checkResult();
        logic [ACC_W-1:0] expVal;
        if (expQ.size() == 0) begin
            $display("A result was delivered at time %0t while none was expected", $time);
            stopOnError();
        end else begin
            expVal = expQ.pop_front();
            receivedCount++;
            assert (dataOut === expVal) else begin
                $display("[FAIL] time %0t dataOut expected %h actual %h", $time, expVal, dataOut);
                stopOnError();
            end
        end
    endtask

    // Transfers are taken at the rising edge
    always @(posedge clkIn) begin
        if (!rstIn && validOut && readyIn) begin
            checkResult();
        end
    end

    initial begin
        repeat (40 * TOTAL_RESULTS + 2000) @(posedge clkIn);
        $display("Timeout: results stopped arriving, %0d of %0d seen",
                 receivedCount, TOTAL_RESULTS);
        stopOnError();
    end

    initial begin
        seed          = 32'h2108;
        receivedCount = 0;
        rstIn         = 1'b1;
        startIn       = 1'b0;
        dataLenIn     = '0;
        filtLenIn     = '0;
        addrIn        = '0;
        wrEnIn        = 1'b0;
        wrDataIn      = '0;
        readyIn       = 1'b1;
        repeat (2) @(posedge clkIn);
        @(negedge clkIn);
        rstIn = 1'b0;

        // Loading time doubles as the idle check after reset
        fillRandom(1'b0, 64);
        fillRandom(1'b1, 8);
        runWindows(32, 8, 1'b0);
        // Partial last vectors
        runWindows(32, 7, 1'b0);
        runWindows(32, 1, 1'b0);
        fillRandom(1'b1, 13);
        runWindows(64, 13, 1'b1);
        // New coefficients and lengths
        fillRandom(1'b1, 5);
        runWindows(40, 5, 1'b0);

        // A stray extra result would show up here
        repeat (4 * PIPE_SKID) @(negedge clkIn);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
src/accelCfgPkg.sv
src/accelAddrPkg.sv
src/convAddrGen.sv
src/convBankedMem.sv
src/convMac.sv
src/convOutFifo.sv
src/convAccelTop.sv
tests/convAccel_checker.sv
tests/convAccelTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module convAccelTb -f files.f -o simConvAccel &&
./obj_dir/simConvAccel | tee /dev/stderr | grep -q "NO ERRORS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
